// ==== verilog.f ====
+incdir+.
bnres_pkg.sv
bn_coef_bank.sv
batch_norm.sv
line_max3.sv
bnres_group.sv
tb_bnres_group.sv

// ==== Bender.yml ====
package:
  name: bnres_group

export_include_dirs:
  - .

sources:
  - bnres_pkg.sv
  - bn_coef_bank.sv
  - batch_norm.sv
  - line_max3.sv
  - bnres_group.sv
  - target: test
    files:
      - tb_bnres_group.sv

// ==== tb_bnres_group.sv ====
`default_nettype none

`include "bnres_consts.svh"

module tb_bnres_group;

timeunit 1ns;
timeprecision 1ps;

localparam int TIMEOUT = 2000;
localparam bnres_pkg::coef_t COEF_ID = '{a: bnres_pkg::coef_a_t'(`BNRES_A_ONE), b: '0};

logic                 sclk;
logic                 arst_n;
logic                 valid;
bnres_pkg::stream_t   din;
logic                 ready;
logic                 param_vld;
bnres_pkg::coef_sel_t param_sel;
bnres_pkg::coef_t     param;
logic                 in_ready;
logic                 out_valid;
bnres_pkg::stream_t   dout;

integer               seed = 32'hd0bf_6a4c;
int                   errors;
int                   checks;
int                   cyc;
int                   bp_span;
bit                   bp_en;
bit                   lat_en;
bit                   stalled;
bnres_pkg::stream_t   held;
bnres_pkg::stream_t   exp_q[$];
int                   cyc_q[$];
bnres_pkg::stream_t   exp_item;
int                   exp_cyc;
// Reference model state
bnres_pkg::coef_t     cm;
bnres_pkg::coef_t     cp;
bnres_pkg::sample_t   mh0;
bnres_pkg::sample_t   mh1;
int                   mcnt;

bnres_group uut
(
	.i_sclk      (sclk),
	.i_arst_n    (arst_n),
	.i_valid     (valid),
	.i_data      (din),
	.i_ready     (ready),
	.i_param_vld (param_vld),
	.i_param_sel (param_sel),
	.i_param     (param),
	.o_in_ready  (in_ready),
	.o_valid     (out_valid),
	.o_data      (dout)
);

initial
begin
	sclk = 1'b0;
	forever #50 sclk = ~sclk;
end

function automatic bnres_pkg::sample_t bn_ref(input bnres_pkg::sample_t x,
	input bnres_pkg::coef_t c);
	longint acc;
	acc = longint'(x) * longint'($signed(c.a)) + longint'($signed(c.b));
	acc = acc >>> `BNRES_QUANT_W;
	return bnres_pkg::sample_t'(acc);
endfunction

task automatic flag_error(input string msg);
	errors++;
	$display("Error at %0t ns: %s", $time, msg);
endtask

task automatic abort_on_timeout(input string what);
	$display("Timeout while waiting for %s", what);
	$display("Checks: %0d, errors: %0d", checks, errors + 1);
	$display("TESTS FAILED");
	$finish;
endtask

// Running max of three within a line, then both normalizations and the wrapped sum
task automatic model_push(input bnres_pkg::stream_t d);
	bnres_pkg::sample_t m;
	bnres_pkg::stream_t e;
	if (d.sol)
		mcnt = 0;
	m = d.data;
	if (mcnt > 0 && mh0 > m)
		m = mh0;
	if (mcnt > 1 && mh1 > m)
		m = mh1;
	mh1 = mh0;
	mh0 = d.data;
	if (mcnt < 2)
		mcnt++;
	e = d;
	e.data = bn_ref(d.data, cm) + bn_ref(m, cp);
	exp_q.push_back(e);
	cyc_q.push_back(cyc);
endtask

// Output monitor
always @(posedge sclk)
begin
	if (arst_n)
	begin
		if (valid && in_ready)
			model_push(din);
		if (!out_valid && dout.data != '0)
			flag_error($sformatf("idle data not zero, got %h", dout.data));
		if (stalled && (!out_valid || dout !== held))
			flag_error("output changed while stalled");
		stalled = out_valid && !ready;
		held = dout;
		if (out_valid && ready)
		begin
			if (exp_q.size() == 0)
			begin
				flag_error("unexpected output with no item pending");
			end
			else
			begin
				exp_item = exp_q.pop_front();
				exp_cyc = cyc_q.pop_front();
				checks++;
				if (dout !== exp_item)
					flag_error($sformatf("output %h, expected %h", dout, exp_item));
				if (lat_en && cyc - exp_cyc != 4)
					flag_error($sformatf("latency %0d cycles, expected 4", cyc - exp_cyc));
			end
		end
		cyc++;
	end
end

// Random back-pressure in spans of 1 to 6 cycles
always @(negedge sclk)
begin
	if (!bp_en)
	begin
		ready = 1'b1;
		bp_span = 0;
	end
	else if (bp_span == 0)
	begin
		ready = ($random(seed) & 1) != 0;
		bp_span = $unsigned($random(seed)) % 6;
	end
	else
	begin
		bp_span--;
	end
end

task automatic send_sample(input bnres_pkg::sample_t x, input logic sof, input logic sol);
	int  t;
	bit  taken;
	valid = 1'b1;
	din.sof = sof;
	din.sol = sol;
	din.data = x;
	t = 0;
	taken = 1'b0;
	while (!taken && t < TIMEOUT)
	begin
		@(posedge sclk);
		taken = in_ready;
		t++;
	end
	if (!taken)
		abort_on_timeout("input ready");
	@(negedge sclk);
	valid = 1'b0;
endtask

task automatic send_line(input int n, input logic with_sof);
	for (int i = 0; i < n; i++)
		send_sample(bnres_pkg::sample_t'($random(seed)), with_sof && i == 0, i == 0);
endtask

task automatic write_coef(input bnres_pkg::coef_sel_t sel, input bnres_pkg::coef_t c);
	param_vld = 1'b1;
	param_sel = sel;
	param = c;
	if (sel == bnres_pkg::BN_MAIN)
		cm = c;
	else
		cp = c;
	@(negedge sclk);
	param_vld = 1'b0;
endtask

task automatic wait_drain();
	int t;
	t = 0;
	while (exp_q.size() != 0 && t < TIMEOUT)
	begin
		@(negedge sclk);
		t++;
	end
	if (exp_q.size() != 0)
		abort_on_timeout("pending outputs to drain");
endtask

task automatic check_reset_defaults();
	if (out_valid || !in_ready || dout.data != '0)
		flag_error("wrong output state after reset");
	send_line(6, 1'b1);
	send_line(5, 1'b0);
	wait_drain();
endtask

task automatic load_coefs_and_stream();
	write_coef(bnres_pkg::BN_MAIN, '{a: bnres_pkg::coef_a_t'(-40000),
		b: bnres_pkg::coef_b_t'(123456789)});
	write_coef(bnres_pkg::BN_POOL, '{a: bnres_pkg::coef_a_t'(98304),
		b: bnres_pkg::coef_b_t'(-5000000)});
	for (int i = 0; i < 4; i++)
		send_line(5, i == 0);
	wait_drain();
endtask

task automatic cross_line_boundary();
	write_coef(bnres_pkg::BN_MAIN, COEF_ID);
	write_coef(bnres_pkg::BN_POOL, COEF_ID);
	for (int i = 0; i < 4; i++)
		send_sample(bnres_pkg::sample_t'(50000000 + i * 1000), i == 0, i == 0);
	// History must not leak into the small line that follows
	for (int i = 0; i < 4; i++)
		send_sample(bnres_pkg::sample_t'(-1000 + i), 1'b0, i == 0);
	wait_drain();
endtask

task automatic stall_randomly();
	bp_en = 1'b1;
	for (int i = 0; i < 6; i++)
		send_line(7, i == 0);
	wait_drain();
	bp_en = 1'b0;
	@(negedge sclk);
endtask

task automatic check_flags_and_idle();
	lat_en = 1'b1;
	for (int i = 0; i < 12; i++)
	begin
		send_sample(bnres_pkg::sample_t'($random(seed)), i % 6 == 0, i % 3 == 0);
		repeat ($unsigned($random(seed)) % 4)
			@(negedge sclk);
	end
	wait_drain();
	lat_en = 1'b0;
endtask

initial
begin
	arst_n = 1'b0;
	valid = 1'b0;
	din = '0;
	ready = 1'b1;
	param_vld = 1'b0;
	param_sel = bnres_pkg::BN_MAIN;
	param = '0;
	errors = 0;
	checks = 0;
	cyc = 0;
	bp_en = 1'b0;
	lat_en = 1'b0;
	stalled = 1'b0;
	cm = COEF_ID;
	cp = COEF_ID;
	mcnt = 0;
	repeat (10) @(posedge sclk);
	@(negedge sclk);
	arst_n = 1'b1;
	@(negedge sclk);
	check_reset_defaults();
	load_coefs_and_stream();
	cross_line_boundary();
	stall_randomly();
	check_flags_and_idle();
	repeat (5) @(negedge sclk);
	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display("TESTS PASSED");
	else
		$display("TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire

// ==== bnres_group.sv ====
`default_nettype none

module bnres_group
(
	input  wire                       i_sclk,
	input  wire                       i_arst_n,
	input  wire                       i_valid,
	input  wire bnres_pkg::stream_t   i_data,
	input  wire                       i_ready,
	input  wire                       i_param_vld,
	input  wire bnres_pkg::coef_sel_t i_param_sel,
	input  wire bnres_pkg::coef_t     i_param,
	output logic                      o_in_ready,
	output logic                      o_valid,
	output bnres_pkg::stream_t        o_data
);

bnres_pkg::coef_t   coef_main;
bnres_pkg::coef_t   coef_pool;
logic               lm_ready;
logic               lm_valid;
bnres_pkg::stream_t lm_data;
bnres_pkg::stream_t main_q;
logic               bn_ready;
logic               bn_valid;
bnres_pkg::stream_t bn_main_data;
bnres_pkg::stream_t bn_pool_data;
logic               out_ready;
bnres_pkg::stream_t out_q;

bn_coef_bank u_coef_bank
(
	.i_sclk      (i_sclk),
	.i_arst_n    (i_arst_n),
	.i_param_vld (i_param_vld),
	.i_param_sel (i_param_sel),
	.i_param     (i_param),
	.o_coef_main (coef_main),
	.o_coef_pool (coef_pool)
);

line_max3 u_line_max3
(
	.i_sclk   (i_sclk),
	.i_arst_n (i_arst_n),
	.i_valid  (i_valid),
	.i_data   (i_data),
	.i_ready  (bn_ready),
	.o_ready  (lm_ready),
	.o_valid  (lm_valid),
	.o_data   (lm_data)
);

assign o_in_ready = lm_ready;

// Main lane delay, shares its valid with line_max3
always_ff @(posedge i_sclk)
begin
	if (i_valid && lm_ready)
	begin
		main_q <= i_data;
	end
end

batch_norm u_bn_main
(
	.i_sclk   (i_sclk),
	.i_arst_n (i_arst_n),
	.i_valid  (lm_valid),
	.i_data   (main_q),
	.i_coef   (coef_main),
	.i_ready  (out_ready),
	.o_ready  (bn_ready),
	.o_valid  (bn_valid),
	.o_data   (bn_main_data)
);

// Runs in lockstep with the main instance
batch_norm u_bn_pool
(
	.i_sclk   (i_sclk),
	.i_arst_n (i_arst_n),
	.i_valid  (lm_valid),
	.i_data   (lm_data),
	.i_coef   (coef_pool),
	.i_ready  (out_ready),
	.o_ready  (),
	.o_valid  (),
	.o_data   (bn_pool_data)
);

assign out_ready = !o_valid || i_ready;

// Residual sum register
always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		o_valid <= 1'b0;
	end
	else if (out_ready)
	begin
		o_valid <= bn_valid;
	end
end

always_ff @(posedge i_sclk)
begin
	if (bn_valid && out_ready)
	begin
		out_q.sof  <= bn_main_data.sof;
		out_q.sol  <= bn_main_data.sol;
		out_q.data <= bn_main_data.data + bn_pool_data.data;
	end
end

always_comb
begin
	o_data = out_q;
	if (!o_valid)
	begin
		o_data.data = '0;
	end
end

endmodule

`default_nettype wire

// ==== line_max3.sv ====
`default_nettype none

module line_max3
(
	input  wire                     i_sclk,
	input  wire                     i_arst_n,
	input  wire                     i_valid,
	input  wire bnres_pkg::stream_t i_data,
	input  wire                     i_ready,
	output logic                    o_ready,
	output logic                    o_valid,
	output bnres_pkg::stream_t      o_data
);

logic               in_xfer;
logic [1:0]         hist_cnt;
logic [1:0]         cnt_eff;
bnres_pkg::sample_t hist_0;
bnres_pkg::sample_t hist_1;
bnres_pkg::sample_t max_val;

assign o_ready = !o_valid || i_ready;
assign in_xfer = i_valid && o_ready;

// History is empty for the first sample of a line
assign cnt_eff = i_data.sol ? 2'd0 : hist_cnt;

always_comb
begin
	max_val = i_data.data;
	if ((cnt_eff != 2'd0) && (hist_0 > max_val))
	begin
		max_val = hist_0;
	end
	if ((cnt_eff == 2'd2) && (hist_1 > max_val))
	begin
		max_val = hist_1;
	end
end

// Number of valid history entries, saturates at two
always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		hist_cnt <= 2'd0;
	end
	else if (in_xfer)
	begin
		hist_cnt <= (cnt_eff == 2'd2) ? 2'd2 : cnt_eff + 2'd1;
	end
end

always_ff @(posedge i_sclk)
begin
	if (in_xfer)
	begin
		hist_0 <= i_data.data;
		hist_1 <= hist_0;
	end
end

always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		o_valid <= 1'b0;
	end
	else if (o_ready)
	begin
		o_valid <= i_valid;
	end
end

always_ff @(posedge i_sclk)
begin
	if (in_xfer)
	begin
		o_data.sof  <= i_data.sof;
		o_data.sol  <= i_data.sol;
		o_data.data <= max_val;
	end
end

endmodule

`default_nettype wire

// ==== batch_norm.sv ====
`default_nettype none

`include "bnres_consts.svh"

module batch_norm
(
	input  wire                     i_sclk,
	input  wire                     i_arst_n,
	input  wire                     i_valid,
	input  wire bnres_pkg::stream_t i_data,
	input  wire bnres_pkg::coef_t   i_coef,
	input  wire                     i_ready,
	output logic                    o_ready,
	output logic                    o_valid,
	output bnres_pkg::stream_t      o_data
);

localparam int PROD_W = `BNRES_DATA_W + `BNRES_COEF_A_W;
// One guard bit for the bias add
localparam int SUM_W  = PROD_W + 1;

logic                     s1_valid;
logic                     s1_sof;
logic                     s1_sol;
logic signed [PROD_W-1:0] s1_prod;
bnres_pkg::coef_b_t       s1_b;
logic                     s1_load;
logic                     s2_ready;
logic                     s2_load;
logic signed [SUM_W-1:0]  s2_sum;
logic signed [SUM_W-1:0]  s2_shift;

assign s2_ready = !o_valid || i_ready;
assign o_ready  = !s1_valid || s2_ready;

assign s1_load = i_valid && o_ready;
assign s2_load = s1_valid && s2_ready;

// Stage one, scale multiply
always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		s1_valid <= 1'b0;
	end
	else if (o_ready)
	begin
		s1_valid <= i_valid;
	end
end

// Bias travels with its product so both come from the same pair
always_ff @(posedge i_sclk)
begin
	if (s1_load)
	begin
		s1_sof  <= i_data.sof;
		s1_sol  <= i_data.sol;
		s1_prod <= $signed(i_data.data) * $signed(i_coef.a);
		s1_b    <= i_coef.b;
	end
end

// Stage two, bias add and requantize
assign s2_sum   = s1_prod + s1_b;
assign s2_shift = s2_sum >>> `BNRES_QUANT_W;

always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		o_valid <= 1'b0;
	end
	else if (s2_ready)
	begin
		o_valid <= s1_valid;
	end
end

always_ff @(posedge i_sclk)
begin
	if (s2_load)
	begin
		o_data.sof  <= s1_sof;
		o_data.sol  <= s1_sol;
		// Low bits only, upper bits wrap away
		o_data.data <= s2_shift[`BNRES_DATA_W-1:0];
	end
end

endmodule

`default_nettype wire

// ==== bn_coef_bank.sv ====
`default_nettype none

`include "bnres_consts.svh"

module bn_coef_bank
(
	input  wire                       i_sclk,
	input  wire                       i_arst_n,
	input  wire                       i_param_vld,
	input  wire bnres_pkg::coef_sel_t i_param_sel,
	input  wire bnres_pkg::coef_t     i_param,
	output bnres_pkg::coef_t          o_coef_main,
	output bnres_pkg::coef_t          o_coef_pool
);

// Identity pair, a = 1.0 and b = 0
localparam bnres_pkg::coef_t COEF_RST = '{
	a: bnres_pkg::coef_a_t'(`BNRES_A_ONE),
	b: '0
};

logic wr_main;
logic wr_pool;

assign wr_main = i_param_vld && (i_param_sel == bnres_pkg::BN_MAIN);
assign wr_pool = i_param_vld && (i_param_sel == bnres_pkg::BN_POOL);

always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		o_coef_main <= COEF_RST;
	end
	else if (wr_main)
	begin
		o_coef_main <= i_param;
	end
end

always_ff @(posedge i_sclk or negedge i_arst_n)
begin
	if (!i_arst_n)
	begin
		o_coef_pool <= COEF_RST;
	end
	else if (wr_pool)
	begin
		o_coef_pool <= i_param;
	end
end

endmodule

`default_nettype wire

// ==== bnres_pkg.sv ====
`default_nettype none

`include "bnres_consts.svh"

package bnres_pkg;

// One feature value
typedef logic signed [`BNRES_DATA_W-1:0] sample_t;

// Scale, QUANT_W fraction bits
typedef logic signed [`BNRES_COEF_A_W-1:0] coef_a_t;

// Bias, already scaled up by QUANT_W
typedef logic signed [`BNRES_COEF_B_W-1:0] coef_b_t;

typedef struct packed
{
	coef_a_t a;
	coef_b_t b;
} coef_t;

// Target of a coefficient write
typedef enum logic
{
	BN_MAIN = 1'b0,
	BN_POOL = 1'b1
} coef_sel_t;

typedef struct packed
{
	logic    sof;
	logic    sol;
	sample_t data;
} stream_t;

endpackage

`default_nettype wire

// ==== bnres_consts.svh ====
`ifndef BNRES_CONSTS_SVH
`define BNRES_CONSTS_SVH

// Feature sample width
`define BNRES_DATA_W 27

// Normalization scale and bias widths
`define BNRES_COEF_A_W 18
`define BNRES_COEF_B_W 34

// Fraction bits of the scale, removed after the multiply-add
`define BNRES_QUANT_W 16

// Scale of 1.0, loaded at reset together with a zero bias
`define BNRES_A_ONE (1 << `BNRES_QUANT_W)

`endif
